//--- include/rps_defs.svh
// move codes, strategy codes, field widths and the blank display pattern
`ifndef RPS_DEFS_SVH
`define RPS_DEFS_SVH

// move encoding, code 3 is never produced
`define RPS_ROCK 2'd0
`define RPS_SCISSOR 2'd1
`define RPS_PAPER 2'd2

// computer strategy select, codes 2 and 3 fall back to cyclic
`define RPS_STRAT_CYCLIC 2'd0
`define RPS_STRAT_MARKOV 2'd1

// field widths
`define RPS_MOVE_W 2
`define RPS_STRAT_W 2
`define RPS_SCORE_W 8
`define RPS_COUNT_W 8
`define RPS_SEG_W 7

// segments are active low
`define RPS_SEG_BLANK 7'h7f

`endif

//--- design/rps_pkg.sv
// shared vector types and the predictor state enum
`include "rps_defs.svh"

package rps_pkg;

	typedef logic [`RPS_MOVE_W-1:0] move_t; // rock, scissor or paper
	typedef logic [`RPS_STRAT_W-1:0] strategy_t; // computer strategy select
	typedef logic [`RPS_SCORE_W-1:0] score_t; // wraps at 256
	typedef logic [`RPS_COUNT_W-1:0] count_t; // saturates at all ones
	typedef logic [`RPS_SEG_W-1:0] seg_t; // gfedcba, active low

	// learning sequence of the Markov predictor
	typedef enum logic [1:0] {
		idle,
		update,
		scan_scissor,
		scan_paper
	} predict_state_t;

endpackage

//--- design/predict_if.sv
// learning handshake and prediction link between opponent and predictor
interface predict_if import rps_pkg::*; ();

	logic learn_valid; // one accepted round to learn from
	logic learn_ready; // predictor idle, prediction stable
	move_t learn_move; // player move of that round
	move_t prediction; // move that beats the predicted player move

	modport opponent (
		output learn_valid,
		output learn_move,
		input learn_ready,
		input prediction
	);

	modport predictor (
		input learn_valid,
		input learn_move,
		output learn_ready,
		output prediction
	);

endinterface

//--- design/markov_predictor.sv
// Markov predictor with transition counts, learning update and row scan
`include "rps_defs.svh"

module markov_predictor import rps_pkg::*; (
	input logic clock,
	input logic reset,
	predict_if.predictor link
);

	predict_state_t state;
	count_t counts [0:2][0:2]; // [previous move][next move]
	logic ready;
	logic first; // no previous move yet
	move_t prev;
	move_t learned; // move taken at the handshake
	move_t best_move; // leader after the scissor compare
	count_t best_count;
	move_t prediction;
	logic paper_wins;
	move_t predicted;

	// the move that beats m
	function automatic move_t counter_move(input move_t m);
		case (m)
			`RPS_ROCK: return `RPS_PAPER;
			`RPS_SCISSOR: return `RPS_ROCK;
			default: return `RPS_SCISSOR;
		endcase
	endfunction

	// strictly greater only, so ties stay with the lower code
	assign paper_wins = counts[prev][`RPS_PAPER] > best_count;
	assign predicted = paper_wins ? `RPS_PAPER : best_move;

	always_ff @(posedge clock or negedge reset) begin
		if (!reset) begin
			state <= idle;
			counts <= '{default: '0};
			ready <= 1'b1;
			first <= 1'b1;
			prev <= `RPS_ROCK;
			learned <= `RPS_ROCK;
			best_move <= `RPS_ROCK;
			best_count <= '0;
			prediction <= `RPS_PAPER; // empty table predicts rock
		end else begin
			case (state)
				idle: begin
					if (link.learn_valid && ready) begin
						learned <= link.learn_move;
						ready <= 1'b0;
						state <= update;
					end else begin
						ready <= 1'b1; // one idle cycle before ready again
					end
				end
				update: begin
					if (!first && counts[prev][learned] != '1)
						counts[prev][learned] <= counts[prev][learned] + 1'b1;
					prev <= learned;
					first <= 1'b0;
					state <= scan_scissor;
				end
				scan_scissor: begin
					if (counts[prev][`RPS_SCISSOR] > counts[prev][`RPS_ROCK]) begin
						best_move <= `RPS_SCISSOR;
						best_count <= counts[prev][`RPS_SCISSOR];
					end else begin
						best_move <= `RPS_ROCK;
						best_count <= counts[prev][`RPS_ROCK];
					end
					state <= scan_paper;
				end
				scan_paper: begin
					prediction <= counter_move(predicted);
					state <= idle;
				end
				default: state <= idle;
			endcase
		end
	end

	assign link.learn_ready = ready;
	assign link.prediction = prediction;

	// opponent must gate its valid with our ready
	a_learn_handshake: assert property (@(posedge clock) disable iff (!reset)
		link.learn_valid |-> link.learn_ready);

	a_prediction_code: assert property (@(posedge clock) disable iff (!reset)
		link.prediction != 2'd3);

endmodule

//--- design/opponent.sv
// player move acceptance, cyclic player and computer move selection
`include "rps_defs.svh"

module opponent import rps_pkg::*; (
	input logic clock,
	input logic reset,
	input move_t move,
	input logic move_valid,
	input strategy_t strategy,
	output logic move_ready,
	output logic round_valid,
	output move_t round_user,
	output move_t round_com,
	predict_if.opponent link
);

	move_t cyclic; // free-running rock, scissor, paper
	move_t com_choice;
	logic accept;

	assign move_ready = link.learn_ready; // every round teaches the predictor
	assign accept = move_valid && link.learn_ready;
	assign link.learn_valid = accept;
	assign link.learn_move = move;

	always_ff @(posedge clock or negedge reset) begin
		if (!reset)
			cyclic <= `RPS_ROCK;
		else if (cyclic == `RPS_PAPER)
			cyclic <= `RPS_ROCK;
		else
			cyclic <= cyclic + 1'b1;
	end

	always_comb begin
		case (strategy)
			`RPS_STRAT_CYCLIC: com_choice = cyclic;
			`RPS_STRAT_MARKOV: com_choice = link.prediction;
			default: com_choice = cyclic; // old reinforcement code and spare
		endcase
	end

	always_ff @(posedge clock or negedge reset) begin
		if (!reset) begin
			round_valid <= 1'b0;
			round_user <= `RPS_ROCK;
			round_com <= `RPS_ROCK;
		end else begin
			round_valid <= accept; // one cycle pulse
			if (accept) begin
				round_user <= move;
				round_com <= com_choice;
			end
		end
	end

endmodule

//--- design/round_referee.sv
// round judging, score keeping and result flags
`include "rps_defs.svh"

module round_referee import rps_pkg::*; (
	input logic clock,
	input logic reset,
	input logic round_valid,
	input move_t round_user,
	input move_t round_com,
	output logic result_valid,
	output logic user_win,
	output logic com_win,
	output logic draw,
	output move_t com_move,
	output score_t user_score,
	output score_t com_score
);

	logic same;
	logic user_beats;
	logic com_beats;

	assign same = round_user == round_com;

	// paper beats rock, rock beats scissor, scissor beats paper
	assign user_beats = (round_user == `RPS_PAPER && round_com == `RPS_ROCK) ||
		(round_user == `RPS_ROCK && round_com == `RPS_SCISSOR) ||
		(round_user == `RPS_SCISSOR && round_com == `RPS_PAPER);

	// same rule from the computer side
	assign com_beats = (round_com == `RPS_PAPER && round_user == `RPS_ROCK) ||
		(round_com == `RPS_ROCK && round_user == `RPS_SCISSOR) ||
		(round_com == `RPS_SCISSOR && round_user == `RPS_PAPER);

	always_ff @(posedge clock or negedge reset) begin
		if (!reset) begin
			result_valid <= 1'b0;
			user_win <= 1'b0;
			com_win <= 1'b0;
			draw <= 1'b0;
			com_move <= `RPS_ROCK;
			user_score <= '0;
			com_score <= '0;
		end else begin
			result_valid <= round_valid;
			if (round_valid) begin // flags hold until next round
				com_move <= round_com;
				draw <= same;
				user_win <= user_beats;
				com_win <= com_beats;
				if (user_beats)
					user_score <= user_score + 1'b1; // wraps
				if (com_beats)
					com_score <= com_score + 1'b1;
			end
		end
	end

	a_one_outcome: assert property (@(posedge clock) disable iff (!reset)
		$onehot0({user_win, com_win, draw}));

endmodule

//--- design/score_display.sv
// seven-segment encoding of both scores and the latest moves
`include "rps_defs.svh"

module score_display import rps_pkg::*; (
	input move_t user_move,
	input move_t com_move,
	input score_t user_score,
	input score_t com_score,
	output seg_t hex0,
	output seg_t hex1,
	output seg_t hex2,
	output seg_t hex3,
	output seg_t hex4,
	output seg_t hex5
);

	// hex digit to active low segments
	function automatic seg_t hex_seg(input logic [3:0] digit);
		case (digit)
			4'h0: return 7'b100_0000;
			4'h1: return 7'b111_1001;
			4'h2: return 7'b010_0100;
			4'h3: return 7'b011_0000;
			4'h4: return 7'b001_1001;
			4'h5: return 7'b001_0010;
			4'h6: return 7'b000_0010;
			4'h7: return 7'b111_1000;
			4'h8: return 7'b000_0000;
			4'h9: return 7'b001_1000;
			4'ha: return 7'b000_1000;
			4'hb: return 7'b000_0011;
			4'hc: return 7'b100_0110;
			4'hd: return 7'b010_0001;
			4'he: return 7'b000_0110;
			4'hf: return 7'b000_1110;
			default: return `RPS_SEG_BLANK;
		endcase
	endfunction

	assign hex0 = hex_seg(user_score[3:0]);
	assign hex1 = hex_seg(user_score[7:4]);
	assign hex2 = hex_seg({2'b00, user_move}); // move code as a digit
	assign hex3 = hex_seg({2'b00, com_move});
	assign hex4 = hex_seg(com_score[3:0]);
	assign hex5 = hex_seg(com_score[7:4]);

endmodule

//--- design/rps_game.sv
// top level with opponent, predictor, referee and display
module rps_game import rps_pkg::*; (
	input logic clock,
	input logic reset,
	input move_t move,
	input logic move_valid,
	output logic move_ready,
	input strategy_t strategy,
	output logic result_valid,
	output logic user_win,
	output logic com_win,
	output logic draw,
	output move_t com_move,
	output score_t user_score,
	output score_t com_score,
	output seg_t hex0,
	output seg_t hex1,
	output seg_t hex2,
	output seg_t hex3,
	output seg_t hex4,
	output seg_t hex5
);

	logic round_valid;
	move_t round_user; // last accepted player move
	move_t round_com;

	predict_if link ();

	opponent u_opponent (
		.clock(clock),
		.reset(reset),
		.move(move),
		.move_valid(move_valid),
		.strategy(strategy),
		.move_ready(move_ready),
		.round_valid(round_valid),
		.round_user(round_user),
		.round_com(round_com),
		.link(link.opponent)
	);

	markov_predictor u_predictor (
		.clock(clock),
		.reset(reset),
		.link(link.predictor)
	);

	round_referee u_referee (
		.clock(clock),
		.reset(reset),
		.round_valid(round_valid),
		.round_user(round_user),
		.round_com(round_com),
		.result_valid(result_valid),
		.user_win(user_win),
		.com_win(com_win),
		.draw(draw),
		.com_move(com_move),
		.user_score(user_score),
		.com_score(com_score)
	);

	score_display u_display (
		.user_move(round_user),
		.com_move(com_move),
		.user_score(user_score),
		.com_score(com_score),
		.hex0(hex0),
		.hex1(hex1),
		.hex2(hex2),
		.hex3(hex3),
		.hex4(hex4),
		.hex5(hex5)
	);

endmodule

//--- bench/rps_game_tb.sv
// testbench for rps_game with stim file rounds, a Markov model, score model and timing checks
`include "rps_defs.svh"

module rps_game_tb import rps_pkg::*; ();

	localparam int move_rock = int'(`RPS_ROCK);
	localparam int move_scissor = int'(`RPS_SCISSOR);
	localparam int move_paper = int'(`RPS_PAPER);
	localparam int strat_markov = int'(`RPS_STRAT_MARKOV);
	localparam int outcome_user = 0;
	localparam int outcome_com = 1;
	localparam int outcome_draw = 2;
	localparam int not_checked = 3; // stim wildcard for com and outcome columns

	logic clock;
	logic reset;
	move_t move;
	logic move_valid;
	logic move_ready;
	strategy_t strategy;
	logic result_valid;
	logic user_win;
	logic com_win;
	logic draw;
	move_t com_move;
	score_t user_score;
	score_t com_score;
	seg_t hex0;
	seg_t hex1;
	seg_t hex2;
	seg_t hex3;
	seg_t hex4;
	seg_t hex5;

	int stim_strategy [$];
	int stim_move [$];
	int stim_com [$];
	int stim_outcome [$];
	int counts [0:2][0:2]; // [previous move][next move]
	int prev_move;
	logic first_round;
	int predicted_com; // computer move of the next Markov round
	int user_total;
	int com_total;
	int cycle_count;
	int cycle_limit;

	rps_game u_rps_game (
		.clock(clock),
		.reset(reset),
		.move(move),
		.move_valid(move_valid),
		.move_ready(move_ready),
		.strategy(strategy),
		.result_valid(result_valid),
		.user_win(user_win),
		.com_win(com_win),
		.draw(draw),
		.com_move(com_move),
		.user_score(user_score),
		.com_score(com_score),
		.hex0(hex0),
		.hex1(hex1),
		.hex2(hex2),
		.hex3(hex3),
		.hex4(hex4),
		.hex5(hex5)
	);

	// paper beats rock, rock beats scissor, scissor beats paper
	function automatic logic beats(input int a, input int b);
		return (a == move_paper && b == move_rock) ||
			(a == move_rock && b == move_scissor) ||
			(a == move_scissor && b == move_paper);
	endfunction

	function automatic int beating_move(input int m);
		if (m == move_rock)
			return move_paper;
		else if (m == move_scissor)
			return move_rock;
		else
			return move_scissor;
	endfunction

	function automatic int judge(input int user, input int com);
		if (user == com)
			return outcome_draw;
		else if (beats(user, com))
			return outcome_user;
		else
			return outcome_com;
	endfunction

	// hex digit on active low gfedcba segments
	function automatic logic [6:0] seg_pattern(input int digit);
		case (digit)
			0: return 7'h40;
			1: return 7'h79;
			2: return 7'h24;
			3: return 7'h30;
			4: return 7'h19;
			5: return 7'h12;
			6: return 7'h02;
			7: return 7'h78;
			8: return 7'h00;
			9: return 7'h18;
			10: return 7'h08;
			11: return 7'h03;
			12: return 7'h46;
			13: return 7'h21;
			14: return 7'h06;
			15: return 7'h0e;
			default: return `RPS_SEG_BLANK;
		endcase
	endfunction

	task automatic stop_with_failure(input string reason);
		$display("%s", reason);
		$display("test failed");
		$fatal(1, "simulation stopped");
	endtask

	task automatic check_value(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		if (actual !== expected)
			stop_with_failure($sformatf("Mismatch %s: got 'h%0h, expected 'h%0h",
				name, actual, expected));
	endtask

	task automatic load_stim();
		int fd;
		int code;
		int s;
		int m;
		int c;
		int o;
		string line;
		fd = $fopen("bench/rps_stim.txt", "r");
		if (fd == 0)
			stop_with_failure("cannot open the stim file bench/rps_stim.txt");
		while (!$feof(fd)) begin
			code = $fgets(line, fd);
			if (code > 0 && $sscanf(line, "%d %d %d %d", s, m, c, o) == 4) begin
				if (m > move_paper)
					stop_with_failure("stim file holds a move code above paper");
				stim_strategy.push_back(s);
				stim_move.push_back(m);
				stim_com.push_back(c);
				stim_outcome.push_back(o);
			end
		end
		$fclose(fd);
	endtask

	// transition count update and row scan, ties keep the lower code
	task automatic learn_round(input int m);
		int best;
		if (!first_round && counts[prev_move][m] < 255)
			counts[prev_move][m]++;
		prev_move = m;
		first_round = 1'b0;
		best = move_rock;
		if (counts[m][move_scissor] > counts[m][best])
			best = move_scissor;
		if (counts[m][move_paper] > counts[m][best])
			best = move_paper;
		predicted_com = beating_move(best);
	endtask

	task automatic drive_line(input int j);
		move <= move_t'(stim_move[j]);
		strategy <= strategy_t'(stim_strategy[j]);
		move_valid <= 1'b1;
	endtask

	task automatic check_result(input int i, input int expected_com);
		int observed;
		int outcome;
		observed = int'(com_move);
		check_value("com_move_code_valid", 32'(com_move != 2'd3), 32'd1);
		if (stim_com[i] != not_checked)
			check_value("com_move", 32'(com_move), 32'(stim_com[i]));
		if (stim_strategy[i] == strat_markov)
			check_value("com_move", 32'(com_move), 32'(expected_com));
		if (stim_outcome[i] != not_checked)
			outcome = stim_outcome[i];
		else
			outcome = judge(stim_move[i], observed);
		check_value("user_win", 32'(user_win), 32'(outcome == outcome_user));
		check_value("com_win", 32'(com_win), 32'(outcome == outcome_com));
		check_value("draw", 32'(draw), 32'(outcome == outcome_draw));
		if (outcome == outcome_user)
			user_total = (user_total + 1) % 256; // score wraps
		if (outcome == outcome_com)
			com_total = (com_total + 1) % 256;
		check_value("user_score", 32'(user_score), 32'(user_total));
		check_value("com_score", 32'(com_score), 32'(com_total));
		check_value("hex0", 32'(hex0), 32'(seg_pattern(user_total % 16)));
		check_value("hex1", 32'(hex1), 32'(seg_pattern(user_total / 16)));
		check_value("hex2", 32'(hex2), 32'(seg_pattern(stim_move[i])));
		check_value("hex3", 32'(hex3), 32'(seg_pattern(observed)));
		check_value("hex4", 32'(hex4), 32'(seg_pattern(com_total % 16)));
		check_value("hex5", 32'(hex5), 32'(seg_pattern(com_total / 16)));
	endtask

	// entered at a falling edge, leaves at the falling edge 4 cycles after acceptance
	task automatic play_round(input int i);
		int expected_com;
		int k;
		while (!(move_valid && move_ready)) begin
			check_value("result_valid", 32'(result_valid), 32'd0);
			@(negedge clock);
		end
		@(posedge clock); // acceptance edge
		if (i + 1 < stim_move.size())
			drive_line(i + 1); // next round offered at once
		else
			move_valid <= 1'b0;
		expected_com = predicted_com;
		learn_round(stim_move[i]);
		for (k = 0; k < 5; k++) begin
			@(negedge clock);
			check_value("result_valid", 32'(result_valid), 32'(k == 1));
			check_value("move_ready", 32'(move_ready), 32'(k == 4));
			if (k == 1)
				check_result(i, expected_com);
		end
	endtask

	initial begin
		clock = 1'b0;
		forever #10 clock = ~clock;
	end

	initial begin
		cycle_count = 0;
		wait (cycle_limit != 0);
		forever begin
			@(posedge clock);
			cycle_count++;
			if (cycle_count >= cycle_limit)
				stop_with_failure($sformatf("timeout, rounds not finished after %0d cycles",
					cycle_count));
		end
	end

	initial begin
		reset = 1'b0;
		move = `RPS_ROCK;
		move_valid = 1'b0;
		strategy = `RPS_STRAT_CYCLIC;
		cycle_limit = 0;
		foreach (counts[r, c])
			counts[r][c] = 0;
		prev_move = move_rock;
		first_round = 1'b1;
		predicted_com = move_paper; // empty table predicts rock
		user_total = 0;
		com_total = 0;
		load_stim();
		if (stim_move.size() == 0)
			stop_with_failure("the stim file holds no rounds");
		cycle_limit = 20 * stim_move.size() + 100;
		repeat (8) @(posedge clock);
		reset <= 1'b1;
		@(negedge clock);
		check_value("move_ready", 32'(move_ready), 32'd1);
		check_value("result_valid", 32'(result_valid), 32'd0);
		check_value("user_win", 32'(user_win), 32'd0);
		check_value("com_win", 32'(com_win), 32'd0);
		check_value("draw", 32'(draw), 32'd0);
		check_value("user_score", 32'(user_score), 32'd0);
		check_value("com_score", 32'(com_score), 32'd0);
		check_value("hex0", 32'(hex0), 32'(seg_pattern(0)));
		check_value("hex1", 32'(hex1), 32'(seg_pattern(0)));
		check_value("hex4", 32'(hex4), 32'(seg_pattern(0)));
		check_value("hex5", 32'(hex5), 32'(seg_pattern(0)));
		@(posedge clock);
		drive_line(0);
		@(negedge clock);
		for (int i = 0; i < stim_move.size(); i++)
			play_round(i);
		$display("test passed");
		$finish;
	end

endmodule

//--- rps_game.f
+incdir+include
design/rps_pkg.sv
design/predict_if.sv
design/markov_predictor.sv
design/opponent.sv
design/round_referee.sv
design/score_display.sv
design/rps_game.sv
bench/rps_game_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log
verilator --binary --timing --assert -Wno-fatal --top-module rps_game_tb \
	-f rps_game.f -o rps_game_sim > build.log 2>&1 \
	|| { cat build.log; echo "build error"; exit 1; }
./obj_dir/rps_game_sim > sim.log 2>&1
cat sim.log
grep -q "test failed" sim.log && { echo "simulation FAILED"; exit 1; }
grep -q "test passed" sim.log || { echo "simulation ended without a result"; exit 1; }
echo "simulation PASSED"

//--- bench/rps_stim.txt
// columns: strategy move expected_com expected_outcome
// moves 0 rock 1 scissor 2 paper, outcome 0 user 1 computer 2 draw, 3 means not checked
0 0 3 3
2 1 3 3
3 2 3 3
0 0 3 3
1 0 0 2
1 0 2 1
1 0 2 1
1 0 2 1
1 1 2 0
1 2 1 1
1 0 2 1
1 1 2 0
1 2 1 1
1 1 2 0
1 1 1 2
1 1 1 2
1 1 1 2
1 1 0 1
1 1 0 1
1 2 0 0
0 0 3 3
1 0 2 1
